// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - common

sources:
  - files:
      - common/icache_pkg.sv
      - icache/icache_ways.sv
      - icache/icache_repl.sv
      - icache/icache_ctrl.sv
      - hdl/icache_top.sv
  - target: test
    files:
      - test/tb_icache.sv

// File: common/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
`define ICACHE_WAYS          4
`define ICACHE_SETS          16
`define ICACHE_LINE_BYTES    16

// bus widths
`define ICACHE_ADDR_WIDTH    32
`define ICACHE_FETCH_WIDTH   32

// derived widths
`define ICACHE_LINE_WIDTH    (`ICACHE_LINE_BYTES * 8)
`define ICACHE_OFFSET_WIDTH  $clog2(`ICACHE_LINE_BYTES)
`define ICACHE_INDEX_WIDTH   $clog2(`ICACHE_SETS)
`define ICACHE_TAG_WIDTH     (`ICACHE_ADDR_WIDTH - `ICACHE_INDEX_WIDTH - `ICACHE_OFFSET_WIDTH)
`define ICACHE_WAY_IDX_WIDTH $clog2(`ICACHE_WAYS)

`endif

// File: common/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

  // one full cache line
  typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;

  // stored tag of one way
  typedef logic [`ICACHE_TAG_WIDTH-1:0] tag_t;

  //////////////////////////////////////////////////
  // fetch port
  //////////////////////////////////////////////////

  // word aligned fetch address
  typedef struct packed {
    logic [`ICACHE_ADDR_WIDTH-1:0] addr;
  } fetch_req_t;

  // instruction word plus the address it belongs to
  typedef struct packed {
    logic [`ICACHE_FETCH_WIDTH-1:0] data;
    logic [`ICACHE_ADDR_WIDTH-1:0]  addr;
  } fetch_rsp_t;

  //////////////////////////////////////////////////
  // refill port
  //////////////////////////////////////////////////

  // line aligned when cacheable, word aligned when nc
  typedef struct packed {
    logic [`ICACHE_ADDR_WIDTH-1:0]    addr;
    logic                             nc;
    logic [`ICACHE_WAY_IDX_WIDTH-1:0] way;
  } refill_req_t;

  // always the aligned line holding the requested word
  typedef struct packed {
    line_t data;
  } refill_rtn_t;

  // controller states, flush first out of reset
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

// File: hdl/icache_top.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     en_i,
  output logic                     miss_o,
  // fetch port
  input  logic                     fetch_vld_i,
  input  icache_pkg::fetch_req_t   fetch_req_i,
  output logic                     fetch_rdy_o,
  output logic                     fetch_rsp_vld_o,
  output icache_pkg::fetch_rsp_t   fetch_rsp_o,
  // refill port
  output logic                     mem_req_vld_o,
  output icache_pkg::refill_req_t  mem_req_o,
  input  logic                     mem_ack_i,
  input  logic                     mem_rtrn_vld_i,
  input  icache_pkg::refill_rtn_t  mem_rtrn_i
);

  // controller to arrays
  logic                              lookup_en;
  logic [`ICACHE_INDEX_WIDTH-1:0]    lookup_idx;
  icache_pkg::tag_t                  cmp_tag;
  logic [`ICACHE_OFFSET_WIDTH-1:0]   cmp_off;
  logic                              wr_en;
  logic [`ICACHE_INDEX_WIDTH-1:0]    wr_idx;
  icache_pkg::tag_t                  wr_tag;
  icache_pkg::line_t                 wr_line;
  logic                              clr_en;
  logic [`ICACHE_INDEX_WIDTH-1:0]    clr_idx;
  // arrays back to controller
  logic                              hit;
  logic [`ICACHE_FETCH_WIDTH-1:0]    hit_word;
  logic [`ICACHE_WAYS-1:0]           vld;
  // replacement
  logic                              lookup_done;
  logic [`ICACHE_WAY_IDX_WIDTH-1:0]  victim_way;
  logic [`ICACHE_WAYS-1:0]           victim_oh;

  icache_ctrl i_ctrl (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .flush_i         ( flush_i         ),
    .en_i            ( en_i            ),
    .fetch_vld_i     ( fetch_vld_i     ),
    .fetch_req_i     ( fetch_req_i     ),
    .fetch_rdy_o     ( fetch_rdy_o     ),
    .fetch_rsp_vld_o ( fetch_rsp_vld_o ),
    .fetch_rsp_o     ( fetch_rsp_o     ),
    .miss_o          ( miss_o          ),
    .mem_req_vld_o   ( mem_req_vld_o   ),
    .mem_req_o       ( mem_req_o       ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_i      ( mem_rtrn_i      ),
    .lookup_en_o     ( lookup_en       ),
    .lookup_idx_o    ( lookup_idx      ),
    .cmp_tag_o       ( cmp_tag         ),
    .cmp_off_o       ( cmp_off         ),
    .wr_en_o         ( wr_en           ),
    .wr_idx_o        ( wr_idx          ),
    .wr_tag_o        ( wr_tag          ),
    .wr_line_o       ( wr_line         ),
    .clr_en_o        ( clr_en          ),
    .clr_idx_o       ( clr_idx         ),
    .hit_i           ( hit             ),
    .hit_word_i      ( hit_word        ),
    .lookup_done_o   ( lookup_done     ),
    .victim_way_i    ( victim_way      )
  );

  icache_ways i_ways (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .lookup_en_i  ( lookup_en  ),
    .lookup_idx_i ( lookup_idx ),
    .cmp_tag_i    ( cmp_tag    ),
    .cmp_off_i    ( cmp_off    ),
    .wr_en_i      ( wr_en      ),
    .wr_idx_i     ( wr_idx     ),
    .wr_tag_i     ( wr_tag     ),
    .wr_line_i    ( wr_line    ),
    .wr_way_oh_i  ( victim_oh  ),
    .clr_en_i     ( clr_en     ),
    .clr_idx_i    ( clr_idx    ),
    .hit_o        ( hit        ),
    .hit_word_o   ( hit_word   ),
    .vld_o        ( vld        )
  );

  // fill_en is the array write strobe
  icache_repl i_repl (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .lookup_done_i ( lookup_done ),
    .fill_en_i     ( wr_en       ),
    .vld_i         ( vld         ),
    .victim_way_o  ( victim_way  ),
    .victim_oh_o   ( victim_oh   )
  );

endmodule

// File: icache/icache_ctrl.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               flush_i,
  input  logic                               en_i,
  // fetch port
  input  logic                               fetch_vld_i,
  input  icache_pkg::fetch_req_t             fetch_req_i,
  output logic                               fetch_rdy_o,
  output logic                               fetch_rsp_vld_o,
  output icache_pkg::fetch_rsp_t             fetch_rsp_o,
  output logic                               miss_o,
  // refill port
  output logic                               mem_req_vld_o,
  output icache_pkg::refill_req_t            mem_req_o,
  input  logic                               mem_ack_i,
  input  logic                               mem_rtrn_vld_i,
  input  icache_pkg::refill_rtn_t            mem_rtrn_i,
  // way arrays
  output logic                               lookup_en_o,
  output logic [`ICACHE_INDEX_WIDTH-1:0]     lookup_idx_o,
  output icache_pkg::tag_t                   cmp_tag_o,
  output logic [`ICACHE_OFFSET_WIDTH-1:0]    cmp_off_o,
  output logic                               wr_en_o,
  output logic [`ICACHE_INDEX_WIDTH-1:0]     wr_idx_o,
  output icache_pkg::tag_t                   wr_tag_o,
  output icache_pkg::line_t                  wr_line_o,
  output logic                               clr_en_o,
  output logic [`ICACHE_INDEX_WIDTH-1:0]     clr_idx_o,
  input  logic                               hit_i,
  input  logic [`ICACHE_FETCH_WIDTH-1:0]     hit_word_i,
  // replacement
  output logic                               lookup_done_o,
  input  logic [`ICACHE_WAY_IDX_WIDTH-1:0]   victim_way_i
);

  icache_pkg::ctrl_state_e             state_d, state_q;
  logic [`ICACHE_ADDR_WIDTH-1:0]       addr_d, addr_q;
  logic                                cache_en_d, cache_en_q;
  logic                                flush_d, flush_q;
  logic [`ICACHE_INDEX_WIDTH-1:0]      flush_cnt_d, flush_cnt_q;
  logic                                flush_done;
  logic                                need_flush;
  logic [`ICACHE_FETCH_WIDTH-1:0]      rtrn_word;

  //////////////////////////////////////////////////
  // address split and port plumbing
  //////////////////////////////////////////////////

  // lookup fields come straight from the incoming request
  assign lookup_idx_o = fetch_req_i.addr[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
  assign cmp_tag_o    = fetch_req_i.addr[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
  assign cmp_off_o    = fetch_req_i.addr[`ICACHE_OFFSET_WIDTH-1:0];

  // refill writes use the registered address
  assign wr_idx_o  = addr_q[`ICACHE_OFFSET_WIDTH +: `ICACHE_INDEX_WIDTH];
  assign wr_tag_o  = addr_q[`ICACHE_ADDR_WIDTH-1 -: `ICACHE_TAG_WIDTH];
  assign wr_line_o = mem_rtrn_i.data;
  assign clr_idx_o = flush_cnt_q;

  // word out of the returned line, nc returns carry the full line too
  assign rtrn_word = mem_rtrn_i.data[{addr_q[`ICACHE_OFFSET_WIDTH-1:0], 3'b000} +:
                                     `ICACHE_FETCH_WIDTH];

  assign fetch_rsp_o.data = (state_q == icache_pkg::MISS) ? rtrn_word : hit_word_i;
  assign fetch_rsp_o.addr = addr_q;

  // nc request asks for the word, cacheable one for the whole line
  assign mem_req_o.addr = cache_en_q ?
                          {addr_q[`ICACHE_ADDR_WIDTH-1:`ICACHE_OFFSET_WIDTH],
                           {`ICACHE_OFFSET_WIDTH{1'b0}}} :
                          {addr_q[`ICACHE_ADDR_WIDTH-1:2], 2'b00};
  assign mem_req_o.nc   = ~cache_en_q;
  assign mem_req_o.way  = victim_way_i;

  // hold new fetches off while a flush is due
  assign need_flush = flush_d | (en_i & ~cache_en_q);

  assign flush_done  = (flush_cnt_q == {`ICACHE_INDEX_WIDTH{1'b1}});
  assign flush_cnt_d = clr_en_o ? (flush_done ? '0 : flush_cnt_q + 1'b1) : flush_cnt_q;

  // capture address on accept
  assign addr_d = lookup_en_o ? fetch_req_i.addr : addr_q;

  //////////////////////////////////////////////////
  // controller FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    // disable acts at once, enable only via flush
    cache_en_d      = cache_en_q & en_i;
    flush_d         = flush_q | flush_i;
    fetch_rdy_o     = 1'b0;
    fetch_rsp_vld_o = 1'b0;
    mem_req_vld_o   = 1'b0;
    miss_o          = 1'b0;
    lookup_en_o     = 1'b0;
    lookup_done_o   = 1'b0;
    wr_en_o         = 1'b0;
    clr_en_o        = 1'b0;

    unique case (state_q)
      // walk all sets and drop their valid bits
      icache_pkg::FLUSH: begin
        clr_en_o = 1'b1;
        if (flush_done) begin
          state_d    = icache_pkg::IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // wait for a fetch
      icache_pkg::IDLE: begin
        fetch_rdy_o = ~need_flush;
        if (need_flush) begin
          state_d = icache_pkg::FLUSH;
        end else if (fetch_vld_i) begin
          lookup_en_o = 1'b1;
          state_d     = icache_pkg::READ;
        end
      end
      // array output is valid here
      icache_pkg::READ: begin
        lookup_done_o = 1'b1;
        if (hit_i && cache_en_q) begin
          fetch_rsp_vld_o = 1'b1;
          state_d         = icache_pkg::IDLE;
          // next lookup overlaps this response
          fetch_rdy_o     = ~need_flush;
          if (!need_flush && fetch_vld_i) begin
            lookup_en_o = 1'b1;
            state_d     = icache_pkg::READ;
          end
        end else begin
          // miss, or cache off so nc access
          mem_req_vld_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = cache_en_q;
            state_d = icache_pkg::MISS;
          end
        end
      end
      // wait for the line
      icache_pkg::MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_rsp_vld_o = 1'b1;
          // a disabled cache keeps its arrays untouched
          wr_en_o         = cache_en_q;
          state_d         = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= icache_pkg::FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  // fetch address
  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

endmodule

// File: icache/icache_repl.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_repl (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              lookup_done_i,
  input  logic                              fill_en_i,
  input  logic [`ICACHE_WAYS-1:0]           vld_i,
  output logic [`ICACHE_WAY_IDX_WIDTH-1:0]  victim_way_o,
  output logic [`ICACHE_WAYS-1:0]           victim_oh_o
);

  logic [7:0]                        lfsr_q;
  logic                              lfsr_fb;
  logic                              all_vld;
  logic                              all_vld_q;
  logic [`ICACHE_WAY_IDX_WIDTH-1:0]  inv_way;
  logic [`ICACHE_WAYS-1:0]           victim_oh;

  //////////////////////////////////////////////////
  // victim choice
  //////////////////////////////////////////////////

  assign all_vld = &vld_i;

  // lowest invalid way, scanned from the top down
  always_comb begin
    inv_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!vld_i[w]) begin
        inv_way = w[`ICACHE_WAY_IDX_WIDTH-1:0];
      end
    end
  end

  // random pick only once the set is full
  assign victim_way_o = all_vld ? lfsr_q[`ICACHE_WAY_IDX_WIDTH-1:0] : inv_way;

  always_comb begin
    victim_oh = '0;
    victim_oh[victim_way_o] = 1'b1;
  end

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_oh_o <= '0;
      all_vld_q   <= 1'b0;
      // any nonzero seed
      lfsr_q      <= 8'hA5;
    end else begin
      if (lookup_done_i) begin
        victim_oh_o <= victim_oh;
        all_vld_q   <= all_vld;
      end
      // advance only when the fill evicted a valid line
      if (fill_en_i && all_vld_q) begin
        lfsr_q <= {lfsr_q[6:0], lfsr_fb};
      end
    end
  end

endmodule

// File: icache/icache_ways.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ways (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // lookup
  input  logic                              lookup_en_i,
  input  logic [`ICACHE_INDEX_WIDTH-1:0]    lookup_idx_i,
  input  icache_pkg::tag_t                  cmp_tag_i,
  input  logic [`ICACHE_OFFSET_WIDTH-1:0]   cmp_off_i,
  // refill write
  input  logic                              wr_en_i,
  input  logic [`ICACHE_INDEX_WIDTH-1:0]    wr_idx_i,
  input  icache_pkg::tag_t                  wr_tag_i,
  input  icache_pkg::line_t                 wr_line_i,
  input  logic [`ICACHE_WAYS-1:0]           wr_way_oh_i,
  // set clear
  input  logic                              clr_en_i,
  input  logic [`ICACHE_INDEX_WIDTH-1:0]    clr_idx_i,
  // registered lookup result
  output logic                              hit_o,
  output logic [`ICACHE_FETCH_WIDTH-1:0]    hit_word_o,
  output logic [`ICACHE_WAYS-1:0]           vld_o
);

  // flop arrays, one tag and one line per way and set
  icache_pkg::tag_t              tag_q  [`ICACHE_WAYS][`ICACHE_SETS];
  icache_pkg::line_t             data_q [`ICACHE_WAYS][`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0]       valid_q [`ICACHE_WAYS];

  logic [`ICACHE_WAYS-1:0]        way_hit;
  logic [`ICACHE_WAYS-1:0]        way_vld;
  logic [`ICACHE_FETCH_WIDTH-1:0] sel_word;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    // tag and line only written on a refill
    always_ff @(posedge clk_i) begin
      if (wr_en_i && wr_way_oh_i[w]) begin
        tag_q[w][wr_idx_i]  <= wr_tag_i;
        data_q[w][wr_idx_i] <= wr_line_i;
      end
    end

    // clear wins, refill and clear never share a cycle anyway
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q[w] <= '0;
      end else if (clr_en_i) begin
        valid_q[w][clr_idx_i] <= 1'b0;
      end else if (wr_en_i && wr_way_oh_i[w]) begin
        valid_q[w][wr_idx_i] <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // tag compare and word select
  //////////////////////////////////////////////////

  always_comb begin
    sel_word = '0;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      way_vld[w] = valid_q[w][lookup_idx_i];
      way_hit[w] = way_vld[w] && (tag_q[w][lookup_idx_i] == cmp_tag_i);
      // at most one way hits, so an or of the gated words selects it
      if (way_hit[w]) begin
        sel_word = sel_word |
                   data_q[w][lookup_idx_i][{cmp_off_i, 3'b000} +: `ICACHE_FETCH_WIDTH];
      end
    end
  end

  // result lands one cycle after the lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_o <= 1'b0;
      vld_o <= '0;
    end else if (lookup_en_i) begin
      hit_o <= |way_hit;
      vld_o <= way_vld;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_en_i) begin
      hit_word_o <= sel_word;
    end
  end

endmodule

// File: project.f
+incdir+common
common/icache_pkg.sv
icache/icache_ways.sv
icache/icache_repl.sv
icache/icache_ctrl.sv
hdl/icache_top.sv
test/tb_icache.sv

// File: test/tb_icache.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module tb_icache;

  localparam int unsigned SEED        = 70597;
  localparam int          RUN_TIMEOUT = 4000;
  localparam logic [31:0] DATA_KEY    = 32'h5A5A_0000;

  // memory model phases
  localparam int MEM_IDLE = 0;
  localparam int MEM_ACK  = 1;
  localparam int MEM_RTRN = 2;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    flush_i;
  logic                    en_i;
  logic                    miss_o;
  logic                    fetch_vld_i;
  icache_pkg::fetch_req_t  fetch_req_i;
  logic                    fetch_rdy_o;
  logic                    fetch_rsp_vld_o;
  icache_pkg::fetch_rsp_t  fetch_rsp_o;
  logic                    mem_req_vld_o;
  icache_pkg::refill_req_t mem_req_o;
  logic                    mem_ack_i;
  logic                    mem_rtrn_vld_i;
  icache_pkg::refill_rtn_t mem_rtrn_i;

  logic [31:0] lcg_state;
  int          err_cnt;
  int          refill_cnt;
  int          miss_cnt;
  int          cyc;
  int          max_lat;
  // fetches still to issue, and the ones in flight with their accept cycle
  logic [31:0] issue_q[$];
  logic [31:0] pend_q[$];
  int          accept_q[$];
  // way field of every acked refill request
  logic [`ICACHE_WAY_IDX_WIDTH-1:0] fill_way_q[$];
  int          mem_phase;
  int          mem_cnt;
  logic [31:0] mem_addr;
  logic        exp_nc;

  icache_top dut_i (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .flush_i         ( flush_i         ),
    .en_i            ( en_i            ),
    .miss_o          ( miss_o          ),
    .fetch_vld_i     ( fetch_vld_i     ),
    .fetch_req_i     ( fetch_req_i     ),
    .fetch_rdy_o     ( fetch_rdy_o     ),
    .fetch_rsp_vld_o ( fetch_rsp_vld_o ),
    .fetch_rsp_o     ( fetch_rsp_o     ),
    .mem_req_vld_o   ( mem_req_vld_o   ),
    .mem_req_o       ( mem_req_o       ),
    .mem_ack_i       ( mem_ack_i       ),
    .mem_rtrn_vld_i  ( mem_rtrn_vld_i  ),
    .mem_rtrn_i      ( mem_rtrn_i      )
  );

  // 100 MHz
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // lcg step that keeps the better upper bits
  function int unsigned rand_below(input int unsigned n);
    lcg_state  = lcg_state * 32'd1103515245 + 32'd12345;
    rand_below = lcg_state[30:16] % n;
  endfunction

  // memory content rule
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return addr ^ DATA_KEY;
  endfunction

  // aligned line around addr with word k in bits 32k up
  function automatic icache_pkg::line_t line_at(input logic [31:0] addr);
    icache_pkg::line_t line;
    logic [31:0]       base;
    base = {addr[31:`ICACHE_OFFSET_WIDTH], {`ICACHE_OFFSET_WIDTH{1'b0}}};
    for (int k = 0; k < `ICACHE_LINE_BYTES / 4; k++) begin
      line[k*32 +: 32] = expected_word(base + 32'(k * 4));
    end
    return line;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    err_cnt++;
    $display("** Error %s: got %h expected %h", name, got, exp);
  endtask

  task automatic report_fault(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic expect_count(input string name, input int got, input int exp);
    if (got != exp) begin
      report_mismatch(name, got, exp);
    end
  endtask

  task automatic print_test_result(input string name, input int start_err);
    if (err_cnt == start_err) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - start_err);
    end
  endtask

  task automatic stop_on_timeout(input string msg);
    $display("timeout: %s", msg);
    $display("refills %0d, misses %0d, errors %0d", refill_cnt, miss_cnt, err_cnt + 1);
    $display("CHECKS FAILED");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // memory model and fetch driver
  //////////////////////////////////////////////////

  // refill request must match the fetch in flight
  task automatic check_request();
    logic [31:0] want;
    if (pend_q.size() == 0) begin
      report_fault("refill request seen with no fetch outstanding");
    end else begin
      want = exp_nc ? pend_q[0] : {pend_q[0][31:`ICACHE_OFFSET_WIDTH],
                                   {`ICACHE_OFFSET_WIDTH{1'b0}}};
      if (mem_req_o.nc !== exp_nc) begin
        report_mismatch("mem_req_o.nc", mem_req_o.nc, exp_nc);
      end
      if (mem_req_o.addr !== want) begin
        report_mismatch("mem_req_o.addr", mem_req_o.addr, want);
      end
    end
  endtask

  // memory side for one falling edge with ack after 0..3 and return after 1..6 cycles
  task automatic step_memory();
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    if (mem_phase == MEM_IDLE && mem_req_vld_o) begin
      mem_cnt   = rand_below(4);
      mem_phase = MEM_ACK;
    end
    if (mem_phase == MEM_ACK) begin
      if (mem_cnt == 0) begin
        mem_ack_i = 1'b1;
        mem_addr  = mem_req_o.addr;
        refill_cnt++;
        fill_way_q.push_back(mem_req_o.way);
        check_request();
        mem_cnt   = 1 + rand_below(6);
        mem_phase = MEM_RTRN;
      end else begin
        mem_cnt--;
      end
    end else if (mem_phase == MEM_RTRN) begin
      mem_cnt--;
      if (mem_cnt == 0) begin
        mem_rtrn_vld_i  = 1'b1;
        mem_rtrn_i.data = line_at(mem_addr);
        mem_phase       = MEM_IDLE;
      end
    end
  endtask

  task automatic check_response();
    logic [31:0] addr;
    int          acc;
    if (pend_q.size() == 0) begin
      report_fault("fetch response seen with no fetch outstanding");
    end else begin
      addr = pend_q.pop_front();
      acc  = accept_q.pop_front();
      if (cyc - acc > max_lat) begin
        max_lat = cyc - acc;
      end
      if (fetch_rsp_o.addr !== addr) begin
        report_mismatch("fetch_rsp_o.addr", fetch_rsp_o.addr, addr);
      end
      if (fetch_rsp_o.data !== expected_word(addr)) begin
        report_mismatch("fetch_rsp_o.data", fetch_rsp_o.data, expected_word(addr));
      end
    end
  endtask

  // issue everything in issue_q, serve refills, check every response
  task automatic run_fetches();
    int          waited;
    logic        rdy;
    logic [31:0] addr;
    waited  = 0;
    max_lat = 0;
    while ((issue_q.size() > 0 || pend_q.size() > 0) && waited < RUN_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
      waited++;
      // ready does not depend on the inputs driven below
      rdy = fetch_rdy_o;
      step_memory();
      if (rdy && issue_q.size() > 0) begin
        addr             = issue_q.pop_front();
        fetch_vld_i      = 1'b1;
        fetch_req_i.addr = addr;
        pend_q.push_back(addr);
        accept_q.push_back(cyc);
      end else begin
        fetch_vld_i = 1'b0;
      end
      // settled values as the next rising edge sees them
      #1;
      if (miss_o) begin
        miss_cnt++;
        if (!mem_ack_i) begin
          report_fault("miss_o pulse outside a refill ack cycle");
        end
      end
      // the returned line answers the fetch in the same cycle
      if (mem_rtrn_vld_i && !fetch_rsp_vld_o) begin
        report_fault("no fetch response in the refill return cycle");
      end
      if (fetch_rsp_vld_o) begin
        check_response();
      end
    end
    @(negedge clk_i);
    cyc++;
    fetch_vld_i    = 1'b0;
    mem_ack_i      = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    if (issue_q.size() > 0 || pend_q.size() > 0) begin
      stop_on_timeout("fetch sequence did not complete");
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic test_cold_miss();
    int e0;
    int r0;
    int m0;
    e0     = err_cnt;
    r0     = refill_cnt;
    m0     = miss_cnt;
    exp_nc = 1'b0;
    issue_q.push_back(32'h0000_0044);
    run_fetches();
    expect_count("refill requests", refill_cnt - r0, 1);
    expect_count("miss_o pulses", miss_cnt - m0, 1);
    print_test_result("cold miss", e0);
  endtask

  // rest of the same line back to back
  task automatic test_hits();
    int e0;
    int r0;
    int m0;
    e0 = err_cnt;
    r0 = refill_cnt;
    m0 = miss_cnt;
    issue_q.push_back(32'h0000_0040);
    issue_q.push_back(32'h0000_0048);
    issue_q.push_back(32'h0000_004C);
    run_fetches();
    expect_count("refill requests", refill_cnt - r0, 0);
    expect_count("miss_o pulses", miss_cnt - m0, 0);
    expect_count("hit latency", max_lat, 1);
    print_test_result("hits", e0);
  endtask

  // five tags into set 8 of a 4-way cache
  task automatic test_replacement();
    int e0;
    int r0;
    e0 = err_cnt;
    r0 = refill_cnt;
    fill_way_q.delete();
    for (int k = 1; k <= 4; k++) begin
      issue_q.push_back(32'(k) * 32'h1000 + 32'h80 + 32'((k % 4) * 4));
    end
    run_fetches();
    expect_count("refill requests", refill_cnt - r0, 4);
    // set 8 starts empty so the fills take ways 0 to 3 in order
    for (int k = 0; k < fill_way_q.size(); k++) begin
      if (fill_way_q[k] !== k) begin
        report_mismatch("mem_req_o.way", fill_way_q[k], k);
      end
    end
    r0 = refill_cnt;
    issue_q.push_back(32'h0000_5084);
    run_fetches();
    expect_count("refill requests", refill_cnt - r0, 1);
    // one line was evicted so at least one refetch misses
    r0 = refill_cnt;
    for (int k = 1; k <= 5; k++) begin
      issue_q.push_back(32'(k) * 32'h1000 + 32'h80 + 32'((k % 4) * 4));
    end
    run_fetches();
    if (refill_cnt - r0 < 1 || refill_cnt - r0 > 5) begin
      report_mismatch("refetch refill requests", refill_cnt - r0, 5);
    end
    print_test_result("replacement", e0);
  endtask

  task automatic test_disabled();
    int e0;
    int r0;
    int m0;
    e0 = err_cnt;
    r0 = refill_cnt;
    m0 = miss_cnt;
    @(negedge clk_i);
    en_i   = 1'b0;
    exp_nc = 1'b1;
    // cached words also go out as nc
    issue_q.push_back(32'h0000_0040);
    issue_q.push_back(32'h0000_0040);
    issue_q.push_back(32'h0000_1084);
    issue_q.push_back(32'h0000_9128);
    run_fetches();
    expect_count("refill requests", refill_cnt - r0, 4);
    expect_count("miss_o pulses", miss_cnt - m0, 0);
    @(negedge clk_i);
    en_i   = 1'b1;
    exp_nc = 1'b0;
    print_test_result("disabled", e0);
  endtask

  task automatic test_flush();
    int e0;
    int r0;
    e0 = err_cnt;
    // enable above went through a flush
    r0 = refill_cnt;
    issue_q.push_back(32'h0000_0040);
    run_fetches();
    expect_count("refill requests after enable", refill_cnt - r0, 1);
    r0 = refill_cnt;
    issue_q.push_back(32'h0000_0040);
    run_fetches();
    expect_count("refill requests on hit", refill_cnt - r0, 0);
    // single cycle flush pulse
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    r0 = refill_cnt;
    issue_q.push_back(32'h0000_0040);
    run_fetches();
    expect_count("refill requests after flush", refill_cnt - r0, 1);
    // off and on again
    @(negedge clk_i);
    en_i = 1'b0;
    repeat (3) @(negedge clk_i);
    en_i = 1'b1;
    r0 = refill_cnt;
    issue_q.push_back(32'h0000_0040);
    run_fetches();
    expect_count("refill requests after re-enable", refill_cnt - r0, 1);
    print_test_result("flush", e0);
  endtask

  // 40 words out of a 1 KB window
  task automatic test_random();
    int e0;
    int r0;
    int m0;
    e0 = err_cnt;
    r0 = refill_cnt;
    m0 = miss_cnt;
    for (int i = 0; i < 40; i++) begin
      issue_q.push_back(32'h0000_8000 + (rand_below(256) << 2));
    end
    run_fetches();
    expect_count("refills against misses", refill_cnt - r0, miss_cnt - m0);
    print_test_result("random stream", e0);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_ni      = 1'b0;
    flush_i     = 1'b0;
    en_i        = 1'b1;
    fetch_vld_i = 1'b0;
    fetch_req_i = '0;
    mem_ack_i   = 1'b0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_i  = '0;
    lcg_state   = SEED;
    err_cnt     = 0;
    refill_cnt  = 0;
    miss_cnt    = 0;
    cyc         = 0;
    max_lat     = 0;
    mem_phase   = MEM_IDLE;
    mem_cnt     = 0;
    mem_addr    = '0;
    exp_nc      = 1'b0;

    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_cold_miss();
    test_hits();
    test_replacement();
    test_disabled();
    test_flush();
    test_random();

    $display("refills %0d, misses %0d, errors %0d", refill_cnt, miss_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
